// ==== nhi_xbar.f ====
rtl/nhi_xbar_pkg.sv
rtl/nhi_addr_decode.sv
rtl/nhi_demux.sv
rtl/nhi_mux.sv
rtl/nhi_xbar.sv
verif/nhi_xbar_tb.sv

// ==== Makefile ====
sim:
	verilator --binary --timing --assert -j 0 --top-module nhi_xbar_tb -Mdir obj_dir -f nhi_xbar.f
	./obj_dir/Vnhi_xbar_tb

clean:
	rm -rf obj_dir

.PHONY: sim clean

// ==== verif/nhi_xbar_tb.sv ====
// Each target model answers at least one cycle after it accepts a request.
// Initiators keep their words apart by address bits 7:6 so concurrent writes never collide
`timescale 1ns/1ns
`default_nettype none

module nhi_xbar_tb;

  localparam int unsigned TimeoutCycles = 200;
  localparam nhi_xbar_pkg::addr_t WinSize     = 32'h0001_0000;
  localparam nhi_xbar_pkg::addr_t HndBase     = 32'h1000_0000;
  localparam nhi_xbar_pkg::addr_t PktBase     = 32'h2000_0000;
  localparam nhi_xbar_pkg::addr_t ProgBase    = 32'h3000_0000;
  localparam nhi_xbar_pkg::addr_t ClusterBase = 32'h4000_0000;
  localparam nhi_xbar_pkg::addr_t HoleBase    = 32'h6000_0000;

  // Expected response and the target that should serve it
  typedef struct packed {
    logic                err;
    logic [1:0]          tgt;
    nhi_xbar_pkg::data_t rdata;
  } expect_t;

  logic                    clk;
  logic                    arst_n;
  nhi_xbar_pkg::addr_map_t addr_map;
  integer                  seed;
  logic                    resp_stall;

  // Initiator index 0 host, 1 NIC inbound, 2 NIC outbound, 3 DMA
  logic [3:0]                    ini_req_valid;
  nhi_xbar_pkg::xbar_req_t       ini_req [4];
  wire [3:0]                     ini_req_ready;
  wire [3:0]                     ini_resp_valid;
  wire nhi_xbar_pkg::xbar_resp_t ini_resp [4];
  logic [3:0]                    ini_resp_ready;

  // Target index 0 handler, 1 packet, 2 program, 3 cluster
  wire [3:0]                     t_req_valid;
  wire nhi_xbar_pkg::xbar_req_t  t_req [4];
  logic [3:0]                    t_req_ready = '0;
  logic [3:0]                    t_resp_valid = '0;
  nhi_xbar_pkg::xbar_resp_t      t_resp [4] = '{default: '0};
  wire [3:0]                     t_resp_ready;

  // Target model state
  logic [3:0]               t_busy;
  int                       t_cnt [4];
  nhi_xbar_pkg::xbar_resp_t t_resp_q [4];
  nhi_xbar_pkg::data_t      t_mem [4][64];
  logic                     t_wr [4][64];
  int                       req_seen_cnt [4];
  int                       hnd_log [$];
  int                       dly_tab [256];
  int                       dly_ptr;

  // Reference state
  nhi_xbar_pkg::data_t ref_mem [4][64];
  logic                ref_wr [4][64];
  expect_t             expected [4];
  int                  issued_cnt [4];
  int                  checked_cnt [4];
  int                  hnd_start;
  int                  seen_before;

  nhi_xbar i_dut (
    .clk_i                (clk),
    .arst_n_i             (arst_n),
    .addr_map_i           (addr_map),
    .host_req_valid_i     (ini_req_valid[0]),
    .host_req_i           (ini_req[0]),
    .host_req_ready_o     (ini_req_ready[0]),
    .host_resp_valid_o    (ini_resp_valid[0]),
    .host_resp_o          (ini_resp[0]),
    .host_resp_ready_i    (ini_resp_ready[0]),
    .ni_req_valid_i       (ini_req_valid[1]),
    .ni_req_i             (ini_req[1]),
    .ni_req_ready_o       (ini_req_ready[1]),
    .ni_resp_valid_o      (ini_resp_valid[1]),
    .ni_resp_o            (ini_resp[1]),
    .ni_resp_ready_i      (ini_resp_ready[1]),
    .no_req_valid_i       (ini_req_valid[2]),
    .no_req_i             (ini_req[2]),
    .no_req_ready_o       (ini_req_ready[2]),
    .no_resp_valid_o      (ini_resp_valid[2]),
    .no_resp_o            (ini_resp[2]),
    .no_resp_ready_i      (ini_resp_ready[2]),
    .edma_req_valid_i     (ini_req_valid[3]),
    .edma_req_i           (ini_req[3]),
    .edma_req_ready_o     (ini_req_ready[3]),
    .edma_resp_valid_o    (ini_resp_valid[3]),
    .edma_resp_o          (ini_resp[3]),
    .edma_resp_ready_i    (ini_resp_ready[3]),
    .hnd_req_valid_o      (t_req_valid[0]),
    .hnd_req_o            (t_req[0]),
    .hnd_req_ready_i      (t_req_ready[0]),
    .hnd_resp_valid_i     (t_resp_valid[0]),
    .hnd_resp_i           (t_resp[0]),
    .hnd_resp_ready_o     (t_resp_ready[0]),
    .pkt_req_valid_o      (t_req_valid[1]),
    .pkt_req_o            (t_req[1]),
    .pkt_req_ready_i      (t_req_ready[1]),
    .pkt_resp_valid_i     (t_resp_valid[1]),
    .pkt_resp_i           (t_resp[1]),
    .pkt_resp_ready_o     (t_resp_ready[1]),
    .prog_req_valid_o     (t_req_valid[2]),
    .prog_req_o           (t_req[2]),
    .prog_req_ready_i     (t_req_ready[2]),
    .prog_resp_valid_i    (t_resp_valid[2]),
    .prog_resp_i          (t_resp[2]),
    .prog_resp_ready_o    (t_resp_ready[2]),
    .cluster_req_valid_o  (t_req_valid[3]),
    .cluster_req_o        (t_req[3]),
    .cluster_req_ready_i  (t_req_ready[3]),
    .cluster_resp_valid_i (t_resp_valid[3]),
    .cluster_resp_i       (t_resp[3]),
    .cluster_resp_ready_o (t_resp_ready[3])
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic int rand_below(input int n);
    int r;
    r = $random(seed);
    return (r & 32'h7fff_ffff) % n;
  endfunction

  function automatic nhi_xbar_pkg::addr_rule_t window(input nhi_xbar_pkg::addr_t base);
    nhi_xbar_pkg::addr_rule_t rule;
    rule.start_addr = base;
    rule.end_addr   = base + WinSize;
    return rule;
  endfunction

  function automatic logic in_window(input nhi_xbar_pkg::addr_t addr,
                                     input nhi_xbar_pkg::addr_t base);
    return (addr >= base) && (addr < base + WinSize);
  endfunction

  // Target tag in the top byte above the low address bits
  function automatic nhi_xbar_pkg::data_t tag_word(input int t, input nhi_xbar_pkg::addr_t addr);
    return {8'(t + 1), addr[23:0]};
  endfunction

  function automatic nhi_xbar_pkg::addr_t pick_base(input int sel);
    case (sel)
      0: return HndBase;
      1: return PktBase;
      2: return ProgBase;
      3: return ClusterBase;
      default: return HoleBase;
    endcase
  endfunction

  // Expected target and data for one access by one initiator
  function automatic expect_t predict(input int ini, input nhi_xbar_pkg::addr_t addr,
                                      input logic we);
    expect_t e;
    int      t;
    int      w;
    t = -1;
    w = int'(addr[7:2]);
    if (ini == 1) begin
      t = 1;
    end else if (in_window(addr, HndBase)) begin
      t = 0;
    end else if (ini == 0) begin
      if (in_window(addr, ProgBase)) begin
        t = 2;
      end
    end else if (in_window(addr, PktBase)) begin
      t = 1;
    end else if (in_window(addr, ClusterBase)) begin
      t = 3;
    end
    if (t < 0) begin
      e.err   = 1'b1;
      e.tgt   = 2'd0;
      e.rdata = '0;
    end else begin
      e.err   = 1'b0;
      e.tgt   = 2'(t);
      e.rdata = (!we && ref_wr[t][w]) ? ref_mem[t][w] : tag_word(t, addr);
    end
    return e;
  endfunction

  // Memory model of one target where a write answers with the tag word
  function automatic nhi_xbar_pkg::xbar_resp_t target_access(input int t,
                                                             input nhi_xbar_pkg::xbar_req_t req);
    nhi_xbar_pkg::xbar_resp_t r;
    int                       w;
    w     = int'(req.addr[7:2]);
    r.err = 1'b0;
    if (req.we) begin
      t_mem[t][w] = req.wdata;
      t_wr[t][w]  = 1'b1;
      r.rdata     = tag_word(t, req.addr);
    end else if (t_wr[t][w]) begin
      r.rdata = t_mem[t][w];
    end else begin
      r.rdata = tag_word(t, req.addr);
    end
    return r;
  endfunction

  function automatic int next_delay();
    dly_ptr = (dly_ptr + 1) % 256;
    return dly_tab[dly_ptr];
  endfunction

  function automatic int total_requests_seen();
    int sum;
    sum = 0;
    for (int t = 0; t < 4; t++) begin
      sum += req_seen_cnt[t];
    end
    return sum;
  endfunction

  task automatic value_error(input string msg);
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
    $display("Test failures found");
    $fatal(1, "stopping at the first mismatch");
  endtask

  task automatic abort_run(input string msg);
    $display("%s at %0t ns", msg, $time);
    $display("Test failures found");
    $fatal(1, "run aborted");
  endtask

  // Target models sample handshakes on the rising edge
  always @(posedge clk) begin
    if (!arst_n) begin
      dly_ptr = 0;
      for (int t = 0; t < 4; t++) begin
        t_busy[t]       = 1'b0;
        t_cnt[t]        = 0;
        t_resp_q[t]     = '0;
        req_seen_cnt[t] = 0;
        for (int w = 0; w < 64; w++) begin
          t_wr[t][w] = 1'b0;
        end
      end
    end else begin
      for (int t = 0; t < 4; t++) begin
        if (t_req_valid[t]) begin
          req_seen_cnt[t]++;
        end
        if (!t_busy[t]) begin
          if (t_req_valid[t] && t_req_ready[t]) begin
            t_resp_q[t] = target_access(t, t_req[t]);
            if (t == 0) begin
              hnd_log.push_back(int'(t_req[t].addr[7:6]));
            end
            t_busy[t] = 1'b1;
            t_cnt[t]  = next_delay();
          end else if (t_req_valid[t] && t_cnt[t] > 0) begin
            t_cnt[t]--;
          end
        end else if (t_resp_valid[t] && t_resp_ready[t]) begin
          t_busy[t] = 1'b0;
          t_cnt[t]  = next_delay();
        end else if (t_cnt[t] > 0) begin
          t_cnt[t]--;
        end
      end
    end
  end

  always @(negedge clk) begin
    for (int t = 0; t < 4; t++) begin
      t_req_ready[t]  = !t_busy[t] && (t_cnt[t] == 0);
      t_resp_valid[t] = t_busy[t] && (t_cnt[t] == 0);
      t_resp[t]       = t_resp_q[t];
    end
  end

  // Compares every response transfer with the reference
  always @(posedge clk) begin
    for (int i = 0; i < 4; i++) begin
      if (ini_resp_valid[i] && ini_resp_ready[i]) begin
        assert (issued_cnt[i] == checked_cnt[i] + 1)
          else abort_run($sformatf("Initiator %0d got a response it never asked for", i));
        assert (ini_resp[i].err == expected[i].err && ini_resp[i].rdata == expected[i].rdata)
          else value_error($sformatf("initiator %0d got err %0b rdata %08h, expected %0b %08h",
                                     i, ini_resp[i].err, ini_resp[i].rdata,
                                     expected[i].err, expected[i].rdata));
        checked_cnt[i]++;
      end
    end
  end

  // One complete transaction on one initiator
  task automatic access(input int ini, input nhi_xbar_pkg::addr_t addr, input logic we,
                        input nhi_xbar_pkg::data_t wdata);
    expect_t e;
    int      guard;
    @(negedge clk);
    ini_resp_ready[ini] = 1'b0;
    e = predict(ini, addr, we);
    if (!e.err && we) begin
      ref_mem[e.tgt][addr[7:2]] = wdata;
      ref_wr[e.tgt][addr[7:2]]  = 1'b1;
    end
    expected[ini] = e;
    issued_cnt[ini]++;
    ini_req[ini]       = '{addr: addr, we: we, wdata: wdata};
    ini_req_valid[ini] = 1'b1;
    guard = 0;
    @(posedge clk);
    while (!ini_req_ready[ini]) begin
      guard++;
      if (guard >= TimeoutCycles) begin
        abort_run($sformatf("Timeout, initiator %0d request was never accepted", ini));
      end
      @(posedge clk);
    end
    @(negedge clk);
    ini_req_valid[ini]  = 1'b0;
    ini_resp_ready[ini] = !resp_stall || (rand_below(2) == 1);
    guard = 0;
    @(posedge clk);
    while (!(ini_resp_valid[ini] && ini_resp_ready[ini])) begin
      guard++;
      if (guard >= TimeoutCycles) begin
        abort_run($sformatf("Timeout, initiator %0d never received its response", ini));
      end
      @(negedge clk);
      ini_resp_ready[ini] = !resp_stall || (rand_below(2) == 1);
      @(posedge clk);
    end
  endtask

  task automatic random_stream(input int ini, input int count);
    nhi_xbar_pkg::addr_t base;
    nhi_xbar_pkg::addr_t addr;
    logic                we;
    nhi_xbar_pkg::data_t wdata;
    for (int n = 0; n < count; n++) begin
      base  = pick_base(rand_below(5));
      addr  = base + nhi_xbar_pkg::addr_t'(ini * 64 + rand_below(16) * 4);
      we    = (rand_below(2) == 1);
      wdata = nhi_xbar_pkg::data_t'($random(seed));
      access(ini, addr, we, wdata);
    end
  endtask

  initial begin
    seed           = 32'hc08d9830;
    arst_n         = 1'b0;
    resp_stall     = 1'b0;
    ini_req_valid  = '0;
    ini_resp_ready = '0;
    for (int i = 0; i < 4; i++) begin
      ini_req[i]     = '0;
      expected[i]    = '0;
      issued_cnt[i]  = 0;
      checked_cnt[i] = 0;
      for (int w = 0; w < 64; w++) begin
        ref_wr[i][w] = 1'b0;
      end
    end
    addr_map.hnd     = window(HndBase);
    addr_map.pkt     = window(PktBase);
    addr_map.prog    = window(ProgBase);
    addr_map.cluster = window(ClusterBase);
    for (int k = 0; k < 256; k++) begin
      dly_tab[k] = rand_below(4);
    end
    repeat (4) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    // Host on handler and program
    access(0, HndBase + 32'h10, 1'b1, 32'hcafe_0001);
    access(0, HndBase + 32'h10, 1'b0, '0);
    access(0, ProgBase + 32'h20, 1'b0, '0);
    access(0, ProgBase + 32'h24, 1'b1, 32'h1234_5678);
    access(0, ProgBase + 32'h24, 1'b0, '0);

    // NIC outbound and DMA over three windows and NIC inbound always to packet
    access(2, HndBase + 32'h80, 1'b0, '0);
    access(2, PktBase + 32'h84, 1'b1, 32'h0b0b_0084);
    access(2, PktBase + 32'h84, 1'b0, '0);
    access(2, ClusterBase + 32'h88, 1'b0, '0);
    access(3, HndBase + 32'hc0, 1'b0, '0);
    access(3, PktBase + 32'hc4, 1'b0, '0);
    access(3, ClusterBase + 32'hc8, 1'b1, 32'hd3a0_00c8);
    access(3, ClusterBase + 32'hc8, 1'b0, '0);
    access(1, HndBase + 32'h40, 1'b0, '0);
    access(1, ClusterBase + 32'h44, 1'b0, '0);
    access(1, PktBase + 32'h48, 1'b1, 32'h1a1a_0048);
    access(1, PktBase + 32'h48, 1'b0, '0);

    // Unmapped addresses never reach a target
    @(negedge clk);
    seen_before = total_requests_seen();
    access(0, 32'h0000_1000, 1'b0, '0);
    access(0, PktBase, 1'b0, '0);
    access(0, ClusterBase + 32'h4, 1'b1, 32'hdead_0004);
    access(2, 32'h5000_0000, 1'b0, '0);
    access(2, ProgBase, 1'b0, '0);
    access(3, HndBase + WinSize, 1'b0, '0);
    access(3, 32'hffff_fffc, 1'b1, 32'hdead_fffc);
    @(negedge clk);
    assert (total_requests_seen() == seen_before)
      else value_error("a target saw a request with an unmapped address");

    // Three initiators on the handler at once
    hnd_start = hnd_log.size();
    fork
      begin
        access(0, HndBase + 32'h00, 1'b0, '0);
        access(0, HndBase + 32'h04, 1'b0, '0);
      end
      begin
        access(2, HndBase + 32'h80, 1'b0, '0);
        access(2, HndBase + 32'h84, 1'b0, '0);
      end
      begin
        access(3, HndBase + 32'hc0, 1'b0, '0);
        access(3, HndBase + 32'hc4, 1'b0, '0);
      end
    join
    assert (hnd_log[hnd_start] != hnd_log[hnd_start+1] &&
            hnd_log[hnd_start] != hnd_log[hnd_start+2] &&
            hnd_log[hnd_start+1] != hnd_log[hnd_start+2])
      else value_error($sformatf("handler served %0d %0d %0d first, not round robin",
                                 hnd_log[hnd_start], hnd_log[hnd_start+1],
                                 hnd_log[hnd_start+2]));

    // Mixed traffic with response-ready stalls
    resp_stall = 1'b1;
    fork
      random_stream(0, 40);
      random_stream(1, 40);
      random_stream(2, 40);
      random_stream(3, 40);
    join

    repeat (2) @(negedge clk);
    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

// ==== rtl/nhi_xbar.sv ====
// Four initiators onto four targets, single-beat channels with valid/ready.
// Program memory is reachable from the host only. NIC inbound reaches packet memory only
`timescale 1ns/1ns
`default_nettype none

module nhi_xbar (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  nhi_xbar_pkg::addr_map_t  addr_map_i,
  // Host
  input  logic                     host_req_valid_i,
  input  nhi_xbar_pkg::xbar_req_t  host_req_i,
  output logic                     host_req_ready_o,
  output logic                     host_resp_valid_o,
  output nhi_xbar_pkg::xbar_resp_t host_resp_o,
  input  logic                     host_resp_ready_i,
  // NIC inbound
  input  logic                     ni_req_valid_i,
  input  nhi_xbar_pkg::xbar_req_t  ni_req_i,
  output logic                     ni_req_ready_o,
  output logic                     ni_resp_valid_o,
  output nhi_xbar_pkg::xbar_resp_t ni_resp_o,
  input  logic                     ni_resp_ready_i,
  // NIC outbound
  input  logic                     no_req_valid_i,
  input  nhi_xbar_pkg::xbar_req_t  no_req_i,
  output logic                     no_req_ready_o,
  output logic                     no_resp_valid_o,
  output nhi_xbar_pkg::xbar_resp_t no_resp_o,
  input  logic                     no_resp_ready_i,
  // Off-cluster DMA
  input  logic                     edma_req_valid_i,
  input  nhi_xbar_pkg::xbar_req_t  edma_req_i,
  output logic                     edma_req_ready_o,
  output logic                     edma_resp_valid_o,
  output nhi_xbar_pkg::xbar_resp_t edma_resp_o,
  input  logic                     edma_resp_ready_i,
  // L2 handler memory
  output logic                     hnd_req_valid_o,
  output nhi_xbar_pkg::xbar_req_t  hnd_req_o,
  input  logic                     hnd_req_ready_i,
  input  logic                     hnd_resp_valid_i,
  input  nhi_xbar_pkg::xbar_resp_t hnd_resp_i,
  output logic                     hnd_resp_ready_o,
  // L2 packet memory
  output logic                     pkt_req_valid_o,
  output nhi_xbar_pkg::xbar_req_t  pkt_req_o,
  input  logic                     pkt_req_ready_i,
  input  logic                     pkt_resp_valid_i,
  input  nhi_xbar_pkg::xbar_resp_t pkt_resp_i,
  output logic                     pkt_resp_ready_o,
  // L2 program memory
  output logic                     prog_req_valid_o,
  output nhi_xbar_pkg::xbar_req_t  prog_req_o,
  input  logic                     prog_req_ready_i,
  input  logic                     prog_resp_valid_i,
  input  nhi_xbar_pkg::xbar_resp_t prog_resp_i,
  output logic                     prog_resp_ready_o,
  // Cluster TCDM
  output logic                     cluster_req_valid_o,
  output nhi_xbar_pkg::xbar_req_t  cluster_req_o,
  input  logic                     cluster_req_ready_i,
  input  logic                     cluster_resp_valid_i,
  input  nhi_xbar_pkg::xbar_resp_t cluster_resp_i,
  output logic                     cluster_resp_ready_o
);

  localparam int unsigned HostNumTargets  = 2;
  localparam int unsigned DmaNumTargets   = 3;
  localparam int unsigned HndNumPorts     = 3;
  localparam int unsigned PktNumPorts     = 3;
  localparam int unsigned ClusterNumPorts = 2;

  // Host rules: 0 handler, 1 program
  nhi_xbar_pkg::addr_rule_t [HostNumTargets-1:0] host_rules;
  // NIC outbound and DMA rules: 0 handler, 1 packet, 2 cluster
  nhi_xbar_pkg::addr_rule_t [DmaNumTargets-1:0]  dma_rules;

  assign host_rules = {addr_map_i.prog, addr_map_i.hnd};
  assign dma_rules  = {addr_map_i.cluster, addr_map_i.pkt, addr_map_i.hnd};

  logic [HostNumTargets-1:0]                     host_tgt_req_valid;
  nhi_xbar_pkg::xbar_req_t  [HostNumTargets-1:0] host_tgt_req;
  logic [HostNumTargets-1:0]                     host_tgt_req_ready;
  logic [HostNumTargets-1:0]                     host_tgt_resp_valid;
  nhi_xbar_pkg::xbar_resp_t [HostNumTargets-1:0] host_tgt_resp;
  logic [HostNumTargets-1:0]                     host_tgt_resp_ready;

  logic [DmaNumTargets-1:0]                      no_tgt_req_valid;
  nhi_xbar_pkg::xbar_req_t  [DmaNumTargets-1:0]  no_tgt_req;
  logic [DmaNumTargets-1:0]                      no_tgt_req_ready;
  logic [DmaNumTargets-1:0]                      no_tgt_resp_valid;
  nhi_xbar_pkg::xbar_resp_t [DmaNumTargets-1:0]  no_tgt_resp;
  logic [DmaNumTargets-1:0]                      no_tgt_resp_ready;

  logic [DmaNumTargets-1:0]                      edma_tgt_req_valid;
  nhi_xbar_pkg::xbar_req_t  [DmaNumTargets-1:0]  edma_tgt_req;
  logic [DmaNumTargets-1:0]                      edma_tgt_req_ready;
  logic [DmaNumTargets-1:0]                      edma_tgt_resp_valid;
  nhi_xbar_pkg::xbar_resp_t [DmaNumTargets-1:0]  edma_tgt_resp;
  logic [DmaNumTargets-1:0]                      edma_tgt_resp_ready;

  nhi_demux #(
    .NumTargets (HostNumTargets)
  ) i_demux_host (
    .clk_i,
    .arst_n_i,
    .rules_i          (host_rules),
    .req_valid_i      (host_req_valid_i),
    .req_i            (host_req_i),
    .req_ready_o      (host_req_ready_o),
    .resp_valid_o     (host_resp_valid_o),
    .resp_o           (host_resp_o),
    .resp_ready_i     (host_resp_ready_i),
    .tgt_req_valid_o  (host_tgt_req_valid),
    .tgt_req_o        (host_tgt_req),
    .tgt_req_ready_i  (host_tgt_req_ready),
    .tgt_resp_valid_i (host_tgt_resp_valid),
    .tgt_resp_i       (host_tgt_resp),
    .tgt_resp_ready_o (host_tgt_resp_ready)
  );

  // Program memory has the host as its only initiator
  assign prog_req_valid_o       = host_tgt_req_valid[1];
  assign prog_req_o             = host_tgt_req[1];
  assign host_tgt_req_ready[1]  = prog_req_ready_i;
  assign host_tgt_resp_valid[1] = prog_resp_valid_i;
  assign host_tgt_resp[1]       = prog_resp_i;
  assign prog_resp_ready_o      = host_tgt_resp_ready[1];

  nhi_demux #(
    .NumTargets (DmaNumTargets)
  ) i_demux_no (
    .clk_i,
    .arst_n_i,
    .rules_i          (dma_rules),
    .req_valid_i      (no_req_valid_i),
    .req_i            (no_req_i),
    .req_ready_o      (no_req_ready_o),
    .resp_valid_o     (no_resp_valid_o),
    .resp_o           (no_resp_o),
    .resp_ready_i     (no_resp_ready_i),
    .tgt_req_valid_o  (no_tgt_req_valid),
    .tgt_req_o        (no_tgt_req),
    .tgt_req_ready_i  (no_tgt_req_ready),
    .tgt_resp_valid_i (no_tgt_resp_valid),
    .tgt_resp_i       (no_tgt_resp),
    .tgt_resp_ready_o (no_tgt_resp_ready)
  );

  nhi_demux #(
    .NumTargets (DmaNumTargets)
  ) i_demux_edma (
    .clk_i,
    .arst_n_i,
    .rules_i          (dma_rules),
    .req_valid_i      (edma_req_valid_i),
    .req_i            (edma_req_i),
    .req_ready_o      (edma_req_ready_o),
    .resp_valid_o     (edma_resp_valid_o),
    .resp_o           (edma_resp_o),
    .resp_ready_i     (edma_resp_ready_i),
    .tgt_req_valid_o  (edma_tgt_req_valid),
    .tgt_req_o        (edma_tgt_req),
    .tgt_req_ready_i  (edma_tgt_req_ready),
    .tgt_resp_valid_i (edma_tgt_resp_valid),
    .tgt_resp_i       (edma_tgt_resp),
    .tgt_resp_ready_o (edma_tgt_resp_ready)
  );

  // Handler ports: 0 host, 1 NIC outbound, 2 DMA
  nhi_mux #(
    .NumPorts (HndNumPorts)
  ) i_mux_hnd (
    .clk_i,
    .arst_n_i,
    .req_valid_i      ({edma_tgt_req_valid[0], no_tgt_req_valid[0], host_tgt_req_valid[0]}),
    .req_i            ({edma_tgt_req[0], no_tgt_req[0], host_tgt_req[0]}),
    .req_ready_o      ({edma_tgt_req_ready[0], no_tgt_req_ready[0], host_tgt_req_ready[0]}),
    .resp_valid_o     ({edma_tgt_resp_valid[0], no_tgt_resp_valid[0], host_tgt_resp_valid[0]}),
    .resp_o           ({edma_tgt_resp[0], no_tgt_resp[0], host_tgt_resp[0]}),
    .resp_ready_i     ({edma_tgt_resp_ready[0], no_tgt_resp_ready[0], host_tgt_resp_ready[0]}),
    .tgt_req_valid_o  (hnd_req_valid_o),
    .tgt_req_o        (hnd_req_o),
    .tgt_req_ready_i  (hnd_req_ready_i),
    .tgt_resp_valid_i (hnd_resp_valid_i),
    .tgt_resp_i       (hnd_resp_i),
    .tgt_resp_ready_o (hnd_resp_ready_o)
  );

  // Packet ports: 0 NIC inbound, 1 NIC outbound, 2 DMA
  nhi_mux #(
    .NumPorts (PktNumPorts)
  ) i_mux_pkt (
    .clk_i,
    .arst_n_i,
    .req_valid_i      ({edma_tgt_req_valid[1], no_tgt_req_valid[1], ni_req_valid_i}),
    .req_i            ({edma_tgt_req[1], no_tgt_req[1], ni_req_i}),
    .req_ready_o      ({edma_tgt_req_ready[1], no_tgt_req_ready[1], ni_req_ready_o}),
    .resp_valid_o     ({edma_tgt_resp_valid[1], no_tgt_resp_valid[1], ni_resp_valid_o}),
    .resp_o           ({edma_tgt_resp[1], no_tgt_resp[1], ni_resp_o}),
    .resp_ready_i     ({edma_tgt_resp_ready[1], no_tgt_resp_ready[1], ni_resp_ready_i}),
    .tgt_req_valid_o  (pkt_req_valid_o),
    .tgt_req_o        (pkt_req_o),
    .tgt_req_ready_i  (pkt_req_ready_i),
    .tgt_resp_valid_i (pkt_resp_valid_i),
    .tgt_resp_i       (pkt_resp_i),
    .tgt_resp_ready_o (pkt_resp_ready_o)
  );

  // Cluster ports: 0 NIC outbound, 1 DMA
  nhi_mux #(
    .NumPorts (ClusterNumPorts)
  ) i_mux_cluster (
    .clk_i,
    .arst_n_i,
    .req_valid_i      ({edma_tgt_req_valid[2], no_tgt_req_valid[2]}),
    .req_i            ({edma_tgt_req[2], no_tgt_req[2]}),
    .req_ready_o      ({edma_tgt_req_ready[2], no_tgt_req_ready[2]}),
    .resp_valid_o     ({edma_tgt_resp_valid[2], no_tgt_resp_valid[2]}),
    .resp_o           ({edma_tgt_resp[2], no_tgt_resp[2]}),
    .resp_ready_i     ({edma_tgt_resp_ready[2], no_tgt_resp_ready[2]}),
    .tgt_req_valid_o  (cluster_req_valid_o),
    .tgt_req_o        (cluster_req_o),
    .tgt_req_ready_i  (cluster_req_ready_i),
    .tgt_resp_valid_i (cluster_resp_valid_i),
    .tgt_resp_i       (cluster_resp_i),
    .tgt_resp_ready_o (cluster_resp_ready_o)
  );

endmodule

`default_nettype wire

// ==== rtl/nhi_mux.sv ====
// Round-robin over NumPorts initiators, one transaction in flight on the target.
// The grant holds until the response reaches the granted port
`timescale 1ns/1ns
`default_nettype none

module nhi_mux #(
  parameter int unsigned NumPorts = 2,
  parameter int unsigned IdxWidth = (NumPorts > 1) ? $clog2(NumPorts) : 1
) (
  input  logic                                    clk_i,
  input  logic                                    arst_n_i,
  // Initiator side
  input  logic [NumPorts-1:0]                     req_valid_i,
  input  nhi_xbar_pkg::xbar_req_t  [NumPorts-1:0] req_i,
  output logic [NumPorts-1:0]                     req_ready_o,
  output logic [NumPorts-1:0]                     resp_valid_o,
  output nhi_xbar_pkg::xbar_resp_t [NumPorts-1:0] resp_o,
  input  logic [NumPorts-1:0]                     resp_ready_i,
  // Target side
  output logic                                    tgt_req_valid_o,
  output nhi_xbar_pkg::xbar_req_t                 tgt_req_o,
  input  logic                                    tgt_req_ready_i,
  input  logic                                    tgt_resp_valid_i,
  input  nhi_xbar_pkg::xbar_resp_t                tgt_resp_i,
  output logic                                    tgt_resp_ready_o
);

  logic [IdxWidth-1:0] rr_q;
  logic [IdxWidth-1:0] gnt_q;
  logic                lock_q;
  logic [IdxWidth-1:0] arb_idx;
  logic                arb_valid;
  logic                req_fire;
  logic                resp_fire;

  // First valid port at or after the pointer
  always_comb begin : p_arb
    int unsigned cand;
    arb_idx   = rr_q;
    arb_valid = 1'b0;
    for (int unsigned k = 0; k < NumPorts; k++) begin
      cand = (32'(rr_q) + k) % NumPorts;
      if (!arb_valid && req_valid_i[cand]) begin
        arb_valid = 1'b1;
        arb_idx   = IdxWidth'(cand);
      end
    end
  end

  assign tgt_req_valid_o = ~lock_q & arb_valid;
  assign tgt_req_o       = req_i[arb_idx];

  always_comb begin
    req_ready_o          = '0;
    req_ready_o[arb_idx] = ~lock_q & arb_valid & tgt_req_ready_i;
  end

  // Response only ever shown to the granted port
  always_comb begin
    resp_valid_o        = '0;
    resp_valid_o[gnt_q] = lock_q & tgt_resp_valid_i;
  end

  assign resp_o           = {NumPorts{tgt_resp_i}};
  assign tgt_resp_ready_o = lock_q & resp_ready_i[gnt_q];

  assign req_fire  = tgt_req_valid_o & tgt_req_ready_i;
  assign resp_fire = tgt_resp_valid_i & tgt_resp_ready_o;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rr_q   <= '0;
      gnt_q  <= '0;
      lock_q <= 1'b0;
    end else if (req_fire) begin
      lock_q <= 1'b1;
      gnt_q  <= arb_idx;
    end else if (resp_fire) begin
      lock_q <= 1'b0;
      // Pointer moves one past the port just served
      rr_q   <= (gnt_q == IdxWidth'(NumPorts - 1)) ? '0 : gnt_q + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/nhi_demux.sv ====
// One transaction in flight. The route is locked from request transfer to response transfer
// A missed address never reaches a target, its error response comes one cycle later
`timescale 1ns/1ns
`default_nettype none

module nhi_demux #(
  parameter int unsigned NumTargets = 2,
  parameter int unsigned IdxWidth   = (NumTargets > 1) ? $clog2(NumTargets) : 1
) (
  input  logic                                      clk_i,
  input  logic                                      arst_n_i,
  input  nhi_xbar_pkg::addr_rule_t [NumTargets-1:0] rules_i,
  // Initiator side
  input  logic                                      req_valid_i,
  input  nhi_xbar_pkg::xbar_req_t                   req_i,
  output logic                                      req_ready_o,
  output logic                                      resp_valid_o,
  output nhi_xbar_pkg::xbar_resp_t                  resp_o,
  input  logic                                      resp_ready_i,
  // Target side
  output logic [NumTargets-1:0]                     tgt_req_valid_o,
  output nhi_xbar_pkg::xbar_req_t  [NumTargets-1:0] tgt_req_o,
  input  logic [NumTargets-1:0]                     tgt_req_ready_i,
  input  logic [NumTargets-1:0]                     tgt_resp_valid_i,
  input  nhi_xbar_pkg::xbar_resp_t [NumTargets-1:0] tgt_resp_i,
  output logic [NumTargets-1:0]                     tgt_resp_ready_o
);

  logic [IdxWidth-1:0] dec_idx;
  logic                dec_miss;
  logic                busy_q;
  logic                err_q;
  logic [IdxWidth-1:0] sel_q;
  logic                idle;
  logic                req_fire;
  logic                resp_fire;

  nhi_addr_decode #(
    .NumRules (NumTargets),
    .IdxWidth (IdxWidth)
  ) i_decode (
    .addr_i  (req_i.addr),
    .rules_i (rules_i),
    .idx_o   (dec_idx),
    .miss_o  (dec_miss)
  );

  assign idle = ~busy_q & ~err_q;

  // Misses are swallowed here, hits see the selected target's ready
  always_comb begin
    tgt_req_valid_o = '0;
    req_ready_o     = 1'b0;
    if (idle) begin
      if (dec_miss) begin
        req_ready_o = 1'b1;
      end else begin
        tgt_req_valid_o[dec_idx] = req_valid_i;
        req_ready_o              = tgt_req_ready_i[dec_idx];
      end
    end
  end

  // Payload goes to all targets, only one sees valid
  assign tgt_req_o = {NumTargets{req_i}};

  always_comb begin
    tgt_resp_ready_o = '0;
    if (err_q) begin
      resp_valid_o = 1'b1;
      resp_o       = '{rdata: '0, err: 1'b1};
    end else begin
      resp_valid_o            = busy_q & tgt_resp_valid_i[sel_q];
      resp_o                  = tgt_resp_i[sel_q];
      tgt_resp_ready_o[sel_q] = busy_q & resp_ready_i;
    end
  end

  assign req_fire  = req_valid_i & req_ready_o;
  assign resp_fire = resp_valid_o & resp_ready_i;

  // req_fire only while idle, resp_fire only while busy or erroring
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q <= 1'b0;
      err_q  <= 1'b0;
      sel_q  <= '0;
    end else if (req_fire) begin
      busy_q <= ~dec_miss;
      err_q  <= dec_miss;
      sel_q  <= dec_idx;
    end else if (resp_fire) begin
      busy_q <= 1'b0;
      err_q  <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/nhi_addr_decode.sv ====
// Purely combinational. Overlapping windows resolve to the lowest rule index
// idx_o is zero whenever miss_o is set
`timescale 1ns/1ns
`default_nettype none

module nhi_addr_decode #(
  parameter int unsigned NumRules = 2,
  parameter int unsigned IdxWidth = (NumRules > 1) ? $clog2(NumRules) : 1
) (
  input  nhi_xbar_pkg::addr_t                     addr_i,
  input  nhi_xbar_pkg::addr_rule_t [NumRules-1:0] rules_i,
  output logic [IdxWidth-1:0]                     idx_o,
  output logic                                    miss_o
);

  logic [NumRules-1:0] match;

  // One comparator pair per window
  for (genvar r = 0; r < NumRules; r++) begin : g_match
    assign match[r] = (addr_i >= rules_i[r].start_addr) &&
                      (addr_i < rules_i[r].end_addr);
  end

  // Scan downwards so the lowest hit is the last assignment
  always_comb begin
    idx_o = '0;
    for (int i = NumRules - 1; i >= 0; i--) begin
      if (match[i]) begin
        idx_o = IdxWidth'(i);
      end
    end
  end

  assign miss_o = ~|match;

endmodule

`default_nettype wire

// ==== rtl/nhi_xbar_pkg.sv ====
// Shared widths and payloads of the crossbar. Each link is one request and one response
// channel carrying single beats. Address windows are half open, start in and end out
`default_nettype none

package nhi_xbar_pkg;

  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;

  // Request payload, write when we is set
  typedef struct packed {
    addr_t addr;
    logic  we;
    data_t wdata;
  } xbar_req_t;

  // Response payload, err flags a decode error
  typedef struct packed {
    data_t rdata;
    logic  err;
  } xbar_resp_t;

  // Matches start_addr <= addr < end_addr
  typedef struct packed {
    addr_t start_addr;
    addr_t end_addr;
  } addr_rule_t;

  typedef struct packed {
    addr_rule_t hnd;
    addr_rule_t pkt;
    addr_rule_t prog;
    addr_rule_t cluster;
  } addr_map_t;

endpackage

`default_nettype wire
